//--- aes_key_mem/aes_key_mem.sv
//--------------------
// Round key generator and 15-entry round key memory
// Expands a 128 or 256 bit key after init, one round key per clock
// SubWord comes from an external combinational S-box
//--------------------
`timescale 1ns/100ps
`default_nettype none
`include "aes_defines.svh"

module aes_key_mem (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic [`AES_KEY_WIDTH-1:0]    key,
  input  aes_pkg::keylen_t             keylen,
  input  logic                         init,
  input  logic [3:0]                   round,
  input  logic [31:0]                  new_sboxw,
  output logic [`AES_BLOCK_WIDTH-1:0]  round_key,
  output logic [31:0]                  sboxw,
  output logic                         ready
);
  import aes_pkg::*;

  // Round key storage, one entry per round
  logic [`AES_BLOCK_WIDTH-1:0] key_mem [0:`AES_256_NUM_ROUNDS];

  // Control state
  key_mem_state_t              state_reg;
  key_mem_state_t              state_next;
  logic [3:0]                  round_ctr_reg;
  logic [3:0]                  last_round;
  logic [7:0]                  rcon_reg;
  logic                        ready_reg;
  logic                        gen_en;

  // Two most recent round keys, prev1 is the newest
  logic [`AES_BLOCK_WIDTH-1:0] prev_key0_reg;
  logic [`AES_BLOCK_WIDTH-1:0] prev_key1_reg;

  // Generator outputs
  logic [`AES_BLOCK_WIDTH-1:0] new_key;
  logic [`AES_BLOCK_WIDTH-1:0] prev0_new;
  logic                        prev0_we;
  logic                        prev1_we;
  logic                        rcon_step;
  logic [31:0]                 rot_sub_w;

  // --------------------
  // Helpers
  // --------------------

  // Word chain of the key expansion, each word folds in the one before
  function automatic logic [127:0] next_key(input logic [127:0] prev, input logic [31:0] t);
    logic [31:0] k0;
    logic [31:0] k1;
    logic [31:0] k2;
    logic [31:0] k3;
    k0 = prev[127:96] ^ t;
    k1 = prev[95:64] ^ k0;
    k2 = prev[63:32] ^ k1;
    k3 = prev[31:0] ^ k2;
    return {k0, k1, k2, k3};
  endfunction

  // Multiply by x in GF(2^8)
  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // --------------------
  // Datapath
  // --------------------

  // Last word of the newest key goes to the S-box
  assign sboxw = prev_key1_reg[31:0];

  // RotWord after SubWord, then rcon into the top byte
  assign rot_sub_w = {new_sboxw[23:0], new_sboxw[31:24]} ^ {rcon_reg, 24'h0};

  assign last_round = (keylen == KEYLEN_128) ? 4'(`AES_128_NUM_ROUNDS)
                                             : 4'(`AES_256_NUM_ROUNDS);

  assign gen_en = (state_reg == CTRL_GENERATE);

  // Read port, rounds past 14 read as zero
  assign round_key = (round <= 4'(`AES_256_NUM_ROUNDS)) ? key_mem[round] : '0;

  assign ready = ready_reg;

  // Next round key for the current round counter
  always_comb begin
    // AES-128 default, every round after 0 steps rcon
    new_key   = next_key(prev_key1_reg, rot_sub_w);
    prev0_new = prev_key1_reg;
    prev0_we  = 1'b0;
    prev1_we  = 1'b1;
    rcon_step = 1'b1;

    if (keylen == KEYLEN_128) begin
      if (round_ctr_reg == 4'd0) begin
        new_key = key[`AES_KEY_WIDTH-1 -: `AES_BLOCK_WIDTH];
      end
    end else begin
      // AES-256 shifts both previous keys on every generated round
      rcon_step = 1'b0;
      prev0_we  = 1'b1;
      if (round_ctr_reg == 4'd0) begin
        // Upper key half
        new_key   = key[`AES_KEY_WIDTH-1 -: `AES_BLOCK_WIDTH];
        prev0_new = key[`AES_KEY_WIDTH-1 -: `AES_BLOCK_WIDTH];
        prev1_we  = 1'b0;
      end else if (round_ctr_reg == 4'd1) begin
        // Lower key half, first rcon becomes 0x01
        new_key   = key[`AES_BLOCK_WIDTH-1:0];
        prev0_we  = 1'b0;
        rcon_step = 1'b1;
      end else if (!round_ctr_reg[0]) begin
        new_key = next_key(prev_key0_reg, rot_sub_w);
      end else begin
        // Odd rounds use plain SubWord
        new_key   = next_key(prev_key0_reg, new_sboxw);
        rcon_step = 1'b1;
      end
    end
  end

  // --------------------
  // Control FSM
  // --------------------
  always_comb begin
    state_next = state_reg;
    case (state_reg)
      CTRL_IDLE: begin
        if (init) begin
          state_next = CTRL_INIT;
        end
      end
      CTRL_INIT: begin
        state_next = CTRL_GENERATE;
      end
      CTRL_GENERATE: begin
        if (round_ctr_reg == last_round) begin
          state_next = CTRL_DONE;
        end
      end
      CTRL_DONE: begin
        state_next = CTRL_IDLE;
      end
      default: begin
        state_next = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_reg     <= CTRL_IDLE;
      round_ctr_reg <= 4'd0;
      rcon_reg      <= 8'h00;
      ready_reg     <= 1'b0;
      for (int i = 0; i <= `AES_256_NUM_ROUNDS; i++) begin
        key_mem[i] <= '0;
      end
    end else begin
      state_reg <= state_next;
      // Ready drops as soon as a new expansion starts
      if ((state_reg == CTRL_IDLE) && init) begin
        ready_reg <= 1'b0;
      end
      if (state_reg == CTRL_DONE) begin
        ready_reg <= 1'b1;
      end
      // 0x8d steps to 0x01 on the first rcon update
      if (state_reg == CTRL_INIT) begin
        round_ctr_reg <= 4'd0;
        rcon_reg      <= 8'h8d;
      end
      if (gen_en) begin
        key_mem[round_ctr_reg] <= new_key;
        round_ctr_reg          <= round_ctr_reg + 4'd1;
        if (rcon_step) begin
          rcon_reg <= xtime(rcon_reg);
        end
      end
    end
  end

  // Previous key window, shifted as rounds are generated
  always_ff @(posedge clk) begin
    if (gen_en && prev0_we) begin
      prev_key0_reg <= prev0_new;
    end
    if (gen_en && prev1_we) begin
      prev_key1_reg <= new_key;
    end
  end

endmodule

`default_nettype wire

//--- aes_key_sched.f
+incdir+common
common/aes_pkg.sv
verilog/aes_sbox.sv
aes_key_mem/aes_key_mem.sv
verilog/aes_key_regs.sv
verilog/aes_key_sched.sv
tb/aes_key_sched_asserts.sv
tb/tb_aes_key_sched.sv

//--- common/aes_defines.svh
//--------------------
// Fixed widths, round counts and the register map of the key schedule
// Included by every RTL file that sizes a port or decodes a bus offset
//--------------------
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// Datapath widths
`define AES_KEY_WIDTH      256
`define AES_BLOCK_WIDTH    128
`define AES_128_NUM_ROUNDS 10
`define AES_256_NUM_ROUNDS 14

// AXI4-Lite bus
`define AXI_ADDR_WIDTH     8
`define AXI_DATA_WIDTH     32

// Register offsets, key word 0 and round key word 0 are most significant
`define REG_CTRL           8'h00
`define REG_STATUS         8'h04
`define REG_ROUND          8'h08
`define REG_KEY0           8'h10
`define REG_RKEY0          8'h30

// Key length select inside REG_CTRL
`define CTRL_KEYLEN_BIT    1

`endif

//--- common/aes_pkg.sv
//--------------------
// Shared types of the key schedule
// Key length, key memory FSM state and bus response codes
//--------------------
`default_nettype none

package aes_pkg;

  // Key length as written into CTRL bit 1
  typedef enum logic [0:0] {
    KEYLEN_128 = 1'b0,
    KEYLEN_256 = 1'b1
  } keylen_t;

  // Key memory controller
  typedef enum logic [2:0] {
    CTRL_IDLE     = 3'd0,
    CTRL_INIT     = 3'd1,
    CTRL_GENERATE = 3'd2,
    CTRL_DONE     = 3'd3
  } key_mem_state_t;

  // AXI4-Lite response, only the two codes used here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the key schedule testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_aes_key_sched \
  -f aes_key_sched.f \
  --Mdir obj_dir \
  -o tb_aes_key_sched
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_aes_key_sched
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

//--- tb/aes_key_sched_asserts.sv
//--------------------
// Concurrent checks on the bus responses and the key memory FSM
// Bound into the key schedule top
//--------------------
`timescale 1ns/100ps
`default_nettype none
`include "aes_defines.svh"

module aes_key_sched_asserts (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       bvalid,
  input  logic                       bready,
  input  aes_pkg::axi_resp_t         bresp,
  input  logic                       rvalid,
  input  logic                       rready,
  input  logic [`AXI_DATA_WIDTH-1:0] rdata,
  input  aes_pkg::axi_resp_t         rresp,
  input  logic                       init,
  input  logic                       ready,
  input  aes_pkg::key_mem_state_t    state
);
  import aes_pkg::*;

  // Write response holds until taken
  assert property (@(posedge clk) disable iff (!reset_n)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else $error("bvalid or bresp changed before bready");

  // Read data holds until taken
  assert property (@(posedge clk) disable iff (!reset_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else $error("rvalid, rdata or rresp changed before rready");

  // A start from idle drops ready
  assert property (@(posedge clk) disable iff (!reset_n)
    ((state == CTRL_IDLE) && init) |=> !ready)
    else $error("ready stayed high after init");

  assert property (@(posedge clk) disable iff (!reset_n)
    state inside {CTRL_IDLE, CTRL_INIT, CTRL_GENERATE, CTRL_DONE})
    else $error("key memory FSM left its legal states");

endmodule

bind aes_key_sched aes_key_sched_asserts u_asserts (
  .clk     (clk),
  .reset_n (reset_n),
  .bvalid  (bvalid),
  .bready  (bready),
  .bresp   (bresp),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .rresp   (rresp),
  .init    (init),
  .ready   (ready),
  .state   (u_key_mem.state_reg)
);

`default_nettype wire

//--- tb/aes_key_trace.txt
# W addr data resp | R addr expected_data expected_resp (hex, resp 0 OKAY, 2 SLVERR)
# P max_polls (decimal), STATUS read until ready
# After reset
R 04 00000000 0
R 30 00000000 0
R 34 00000000 0
R 38 00000000 0
R 3c 00000000 0
# AES-128 key 2b7e1516 28aed2a6 abf71588 09cf4f3c
W 10 2b7e1516 0
W 14 28aed2a6 0
W 18 abf71588 0
W 1c 09cf4f3c 0
W 00 00000001 0
P 50
W 08 00000000 0
R 30 2b7e1516 0
R 34 28aed2a6 0
R 38 abf71588 0
R 3c 09cf4f3c 0
W 08 00000001 0
R 30 a0fafe17 0
R 34 88542cb1 0
R 38 23a33939 0
R 3c 2a6c7605 0
W 08 00000005 0
R 30 d4d1c6f8 0
R 34 7c839d87 0
R 38 caf2b8bc 0
R 3c 11f915bc 0
W 08 0000000a 0
R 30 d014f9a8 0
R 34 c9ee2589 0
R 38 e13f0cc8 0
R 3c b6630ca6 0
# AES-256 key 603deb10 .. 0914dff4
W 10 603deb10 0
W 14 15ca71be 0
W 18 2b73aef0 0
W 1c 857d7781 0
W 20 1f352c07 0
W 24 3b6108d7 0
W 28 2d9810a3 0
W 2c 0914dff4 0
W 00 00000003 0
P 50
W 08 00000000 0
R 30 603deb10 0
R 34 15ca71be 0
R 38 2b73aef0 0
R 3c 857d7781 0
W 08 00000001 0
R 30 1f352c07 0
R 34 3b6108d7 0
R 38 2d9810a3 0
R 3c 0914dff4 0
W 08 00000002 0
R 30 9ba35411 0
R 34 8e6925af 0
R 38 a51a8b5f 0
R 3c 2067fcde 0
W 08 00000007 0
R 30 98c5bfc9 0
R 34 bebd198e 0
R 38 268c3ba7 0
R 3c 09e04214 0
W 08 0000000e 0
R 30 fe4890d1 0
R 34 e6188d0b 0
R 38 046df344 0
R 3c 706c631e 0
# Register readback, start bit reads zero
R 10 603deb10 0
R 2c 0914dff4 0
R 00 00000002 0
R 08 0000000e 0
# Unmapped offsets
W 0c ffffffff 2
R 0c 00000000 2
W 40 ffffffff 2
R 40 00000000 2
R 00 00000002 0
R 08 0000000e 0
R 14 15ca71be 0
# New AES-128 key 00010203 .. 0c0d0e0f
W 10 00010203 0
W 14 04050607 0
W 18 08090a0b 0
W 1c 0c0d0e0f 0
W 00 00000001 0
R 04 00000000 0
P 50
R 04 00000001 0
R 00 00000000 0
W 08 00000000 0
R 30 00010203 0
R 34 04050607 0
R 38 08090a0b 0
R 3c 0c0d0e0f 0
W 08 00000001 0
R 30 d6aa74fd 0
R 34 d2af72fa 0
R 38 daa678f1 0
R 3c d6ab76fe 0
W 08 0000000a 0
R 30 13111d7f 0
R 34 e3944a17 0
R 38 f307a78b 0
R 3c 4d2b30c5 0

//--- tb/tb_aes_key_sched.sv
//--------------------
// Trace-driven testbench of the AES key schedule engine
// Replays bus writes, status polls and expected reads from the trace file
// with random back-pressure on the response channels
//--------------------
`timescale 1ns/100ps
`default_nettype none
`include "aes_defines.svh"

module tb_aes_key_sched;
  import aes_pkg::*;

  localparam int    CLK_HALF   = 50;
  localparam string TRACE_FILE = "tb/aes_key_trace.txt";

  logic                       clk = 1'b0;
  logic                       reset_n;
  logic [`AXI_ADDR_WIDTH-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [`AXI_DATA_WIDTH-1:0] wdata;
  logic                       wvalid;
  logic                       wready;
  axi_resp_t                  bresp;
  logic                       bvalid;
  logic                       bready;
  logic [`AXI_ADDR_WIDTH-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [`AXI_DATA_WIDTH-1:0] rdata;
  axi_resp_t                  rresp;
  logic                       rvalid;
  logic                       rready;

  // Back-pressure generator and run limit
  logic [31:0]                lcg_state;
  int                         cycle_count = 0;
  int                         cycle_limit = 0;

  aes_key_sched DUT (
    .clk     (clk),
    .reset_n (reset_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  // 100 ns clock
  always #(CLK_HALF) clk = ~clk;

  // Run limit, set once the trace length is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycle_limit);
      $display("Checks failed");
      $fatal(1, "Run stopped at the cycle limit");
    end
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Hold off the response ready for 0 to 3 cycles
  task automatic random_stall();
    int n;
    lcg_state = lcg_next(lcg_state);
    n = int'(lcg_state[31:30]);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t actual,
                            input axi_resp_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
    end
  endtask

  task automatic check_keylen(input string name, input keylen_t actual,
                              input keylen_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t: %s = %h, expected %h",
                               $time, name, actual, expected));
    end
  endtask

  // Single-bit handshake outputs
  task automatic check_flag(input string name, input logic actual,
                            input logic expected);
    if (actual !== expected) begin
      report_failure($sformatf("** Error at %0t: %s = %b, expected %b",
                               $time, name, actual, expected));
    end
  endtask

  // --------------------
  // AXI4-Lite driver
  // --------------------

  // Starts and ends on a falling edge, bvalid shows the accept
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output axi_resp_t resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    // No response pending, so both readies are offered in this cycle
    #(CLK_HALF / 2);
    check_flag("awready", awready, 1'b1);
    check_flag("wready", wready, 1'b1);
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    // Readies pulse for the accept cycle only
    check_flag("awready", awready, 1'b0);
    check_flag("wready", wready, 1'b0);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    resp    = bresp;
    random_stall();
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output axi_resp_t resp);
    araddr  = addr;
    arvalid = 1'b1;
    // No read data pending, so arready is offered in this cycle
    #(CLK_HALF / 2);
    check_flag("arready", arready, 1'b1);
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    check_flag("arready", arready, 1'b0);
    arvalid = 1'b0;
    data    = rdata;
    resp    = rresp;
    random_stall();
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // Read STATUS until ready or until the poll budget is used up
  task automatic poll_ready(input int max_polls);
    logic [31:0] d;
    axi_resp_t   r;
    logic        seen;
    seen = 1'b0;
    for (int i = 0; (i < max_polls) && !seen; i++) begin
      axi_read(`REG_STATUS, d, r);
      check_resp("rresp of STATUS", r, RESP_OKAY);
      seen = d[0];
    end
    if (!seen) begin
      report_failure($sformatf("Key expansion did not finish within %0d polls", max_polls));
    end
  endtask

  // --------------------
  // Trace replay
  // --------------------
  initial begin
    logic [63:0]      tok;
    logic [8*128-1:0] line_buf;
    logic [31:0]      addr_v;
    logic [31:0]      data_v;
    logic [31:0]      resp_v;
    logic [31:0]      rd_d;
    axi_resp_t        r;
    keylen_t          keylen_exp;
    int               fd;
    int               n;
    int               polls;
    int               line_count;
    logic             trace_done;

    reset_n    = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    lcg_state  = 32'he8f6_1d3d;
    keylen_exp = KEYLEN_128;

    // First pass sizes the run limit
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      report_failure("The trace file could not be opened");
    end
    line_count = 0;
    while (!$feof(fd)) begin
      if ($fgets(line_buf, fd) != 0) begin
        line_count = line_count + 1;
      end
    end
    $fclose(fd);
    cycle_limit = line_count * 40 + 100;
    fd = $fopen(TRACE_FILE, "r");

    // Two cycles of reset, released on a falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    trace_done = 1'b0;
    while (!trace_done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        trace_done = 1'b1;
      end else if (tok[7:0] == "#") begin
        n = $fgets(line_buf, fd);
      end else if (tok[7:0] == "W") begin
        n = $fscanf(fd, "%h %h %h", addr_v, data_v, resp_v);
        if (n != 3) report_failure("A write line of the trace is incomplete");
        axi_write(addr_v[7:0], data_v, r);
        check_resp($sformatf("bresp at %h", addr_v[7:0]), r, axi_resp_t'(resp_v[1:0]));
        // Key length last written to CTRL
        if (addr_v[7:0] == `REG_CTRL) begin
          keylen_exp = keylen_t'(data_v[`CTRL_KEYLEN_BIT]);
        end
      end else if (tok[7:0] == "R") begin
        n = $fscanf(fd, "%h %h %h", addr_v, data_v, resp_v);
        if (n != 3) report_failure("A read line of the trace is incomplete");
        axi_read(addr_v[7:0], rd_d, r);
        check_resp($sformatf("rresp at %h", addr_v[7:0]), r, axi_resp_t'(resp_v[1:0]));
        // CTRL also carries the key length
        if (addr_v[7:0] == `REG_CTRL) begin
          check_keylen("keylen", keylen_t'(rd_d[`CTRL_KEYLEN_BIT]), keylen_exp);
        end
        check_data($sformatf("rdata at %h", addr_v[7:0]), rd_d, data_v);
      end else if (tok[7:0] == "P") begin
        n = $fscanf(fd, "%d", polls);
        if (n != 1) report_failure("A poll line of the trace is incomplete");
        poll_ready(polls);
      end else begin
        report_failure("The trace holds an unknown operation");
      end
    end
    $fclose(fd);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/aes_key_regs.sv
//--------------------
// AXI4-Lite register block of the key schedule
// Holds key, key length, round select and start, reads back round keys
//--------------------
`timescale 1ns/100ps
`default_nettype none
`include "aes_defines.svh"

module aes_key_regs (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic [`AXI_ADDR_WIDTH-1:0]   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [`AXI_DATA_WIDTH-1:0]   wdata,
  input  logic                         wvalid,
  output logic                         wready,
  output aes_pkg::axi_resp_t           bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [`AXI_ADDR_WIDTH-1:0]   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [`AXI_DATA_WIDTH-1:0]   rdata,
  output aes_pkg::axi_resp_t           rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [`AES_KEY_WIDTH-1:0]    key,
  output aes_pkg::keylen_t             keylen,
  output logic                         init,
  output logic [3:0]                   round,
  input  logic [`AES_BLOCK_WIDTH-1:0]  round_key,
  input  logic                         ready
);
  import aes_pkg::*;

  // Key words, word 0 most significant
  logic [`AXI_DATA_WIDTH-1:0] key_word [8];
  keylen_t                    keylen_reg;
  logic [3:0]                 round_reg;
  logic                       init_reg;

  // Response channels
  logic                       bvalid_reg;
  axi_resp_t                  bresp_reg;
  logic                       rvalid_reg;
  axi_resp_t                  rresp_reg;
  logic [`AXI_DATA_WIDTH-1:0] rdata_reg;

  logic                       wr_accept;
  logic                       rd_accept;
  logic [`AXI_ADDR_WIDTH-1:0] wr_key_off;
  logic [`AXI_ADDR_WIDTH-1:0] rd_key_off;
  logic [`AXI_ADDR_WIDTH-1:0] rd_rkey_off;
  logic [`AXI_DATA_WIDTH-1:0] rd_value;
  logic                       rd_mapped;

  // Aligned offsets inside the key word window
  function automatic logic is_key_addr(input logic [`AXI_ADDR_WIDTH-1:0] a);
    return (a[1:0] == 2'b00) && (a >= `REG_KEY0) && (a < `REG_RKEY0);
  endfunction

  // Aligned offsets inside the round key window
  function automatic logic is_rkey_addr(input logic [`AXI_ADDR_WIDTH-1:0] a);
    return (a[1:0] == 2'b00) && (a >= `REG_RKEY0) && (a < `REG_RKEY0 + 8'h10);
  endfunction

  function automatic logic is_mapped(input logic [`AXI_ADDR_WIDTH-1:0] a);
    return (a == `REG_CTRL) || (a == `REG_STATUS) || (a == `REG_ROUND) ||
           is_key_addr(a) || is_rkey_addr(a);
  endfunction

  // --------------------
  // Write channel
  // --------------------

  // Address and data taken together, one response outstanding
  assign wr_accept  = awvalid && wvalid && !bvalid_reg;
  assign awready    = wr_accept;
  assign wready     = wr_accept;
  assign wr_key_off = awaddr - `REG_KEY0;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bvalid_reg <= 1'b0;
      bresp_reg  <= RESP_OKAY;
      keylen_reg <= KEYLEN_128;
      round_reg  <= 4'd0;
      init_reg   <= 1'b0;
    end else begin
      // Start is a single cycle pulse
      init_reg <= 1'b0;
      if (bvalid_reg && bready) begin
        bvalid_reg <= 1'b0;
      end
      if (wr_accept) begin
        bvalid_reg <= 1'b1;
        bresp_reg  <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
        if (awaddr == `REG_CTRL) begin
          init_reg   <= wdata[0];
          keylen_reg <= keylen_t'(wdata[`CTRL_KEYLEN_BIT]);
        end
        if (awaddr == `REG_ROUND) begin
          round_reg <= wdata[3:0];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept && is_key_addr(awaddr)) begin
      key_word[wr_key_off[4:2]] <= wdata;
    end
  end

  // --------------------
  // Read channel
  // --------------------
  assign rd_accept   = arvalid && !rvalid_reg;
  assign arready     = rd_accept;
  assign rd_key_off  = araddr - `REG_KEY0;
  assign rd_rkey_off = araddr - `REG_RKEY0;

  // Read mux, start bit always reads zero
  always_comb begin
    rd_value  = '0;
    rd_mapped = 1'b1;
    case (araddr)
      `REG_CTRL:   rd_value[`CTRL_KEYLEN_BIT] = keylen_reg;
      `REG_STATUS: rd_value[0] = ready;
      `REG_ROUND:  rd_value[3:0] = round_reg;
      default: begin
        if (is_key_addr(araddr)) begin
          rd_value = key_word[rd_key_off[4:2]];
        end else if (is_rkey_addr(araddr)) begin
          // Word 0 is the top of the round key
          rd_value = round_key[{~rd_rkey_off[3:2], 5'b00000} +: 32];
        end else begin
          rd_mapped = 1'b0;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rvalid_reg <= 1'b0;
    end else begin
      if (rvalid_reg && rready) begin
        rvalid_reg <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_reg <= 1'b1;
      end
    end
  end

  // Data captured at accept time
  always_ff @(posedge clk) begin
    if (rd_accept) begin
      rdata_reg <= rd_value;
      rresp_reg <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Outputs
  assign bvalid = bvalid_reg;
  assign bresp  = bresp_reg;
  assign rvalid = rvalid_reg;
  assign rresp  = rresp_reg;
  assign rdata  = rdata_reg;
  assign key    = {key_word[0], key_word[1], key_word[2], key_word[3],
                   key_word[4], key_word[5], key_word[6], key_word[7]};
  assign keylen = keylen_reg;
  assign init   = init_reg;
  assign round  = round_reg;

endmodule

`default_nettype wire

//--- verilog/aes_key_sched.sv
//--------------------
// Top of the AES key schedule engine
// AXI4-Lite register block steering the key memory and its S-box
//--------------------
`timescale 1ns/100ps
`default_nettype none
`include "aes_defines.svh"

module aes_key_sched (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [`AXI_DATA_WIDTH-1:0]  wdata,
  input  logic                        wvalid,
  output logic                        wready,
  output aes_pkg::axi_resp_t          bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [`AXI_ADDR_WIDTH-1:0]  araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [`AXI_DATA_WIDTH-1:0]  rdata,
  output aes_pkg::axi_resp_t          rresp,
  output logic                        rvalid,
  input  logic                        rready
);
  import aes_pkg::*;

  // Register block to key memory
  logic [`AES_KEY_WIDTH-1:0]   key;
  keylen_t                     keylen;
  logic                        init;
  logic [3:0]                  round;
  logic [`AES_BLOCK_WIDTH-1:0] round_key;
  logic                        ready;

  // Key memory to S-box and back
  logic [31:0]                 sboxw;
  logic [31:0]                 new_sboxw;

  aes_key_regs u_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .key       (key),
    .keylen    (keylen),
    .init      (init),
    .round     (round),
    .round_key (round_key),
    .ready     (ready)
  );

  aes_key_mem u_key_mem (
    .clk       (clk),
    .reset_n   (reset_n),
    .key       (key),
    .keylen    (keylen),
    .init      (init),
    .round     (round),
    .new_sboxw (new_sboxw),
    .round_key (round_key),
    .sboxw     (sboxw),
    .ready     (ready)
  );

  // SubWord in the same cycle as the key memory asks for it
  aes_sbox u_sbox (
    .sboxw     (sboxw),
    .new_sboxw (new_sboxw)
  );

endmodule

`default_nettype wire

//--- verilog/aes_sbox.sv
//--------------------
// Combinational SubWord, four forward S-box lookups
//--------------------
`timescale 1ns/100ps
`default_nettype none

module aes_sbox (
  input  logic [31:0] sboxw,
  output logic [31:0] new_sboxw
);

  // Forward S-box, row picked by the high nibble, byte 0 leftmost
  localparam logic [127:0] SBOX_ROWS [16] = '{
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Low nibble counts bytes from the left end of the row
  function automatic logic [7:0] sub_byte(input logic [7:0] b);
    logic [127:0] row;
    row = SBOX_ROWS[b[7:4]];
    return row[{~b[3:0], 3'b000} +: 8];
  endfunction

  // Each byte substituted on its own
  assign new_sboxw = {sub_byte(sboxw[31:24]),
                      sub_byte(sboxw[23:16]),
                      sub_byte(sboxw[15:8]),
                      sub_byte(sboxw[7:0])};

endmodule

`default_nettype wire
